//--- Makefile
TOP := mem_stage_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f vlog.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f vlog.f

clean:
	rm -rf obj_dir $(LOG)

//--- tests/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    localparam int WIN         = 16;
    localparam int ROUNDS      = 32;
    localparam int IMEM_STORES = 12;
    localparam int LED_STORES  = 6;
    localparam int PRE_RETIRES = 3;
    localparam int RETIRES     = 10;
    localparam int CYCLE_GAP   = 7;
    localparam int RANDOM_OPS  = 20;
    localparam int OPS = WIN + ROUNDS * 6 + IMEM_STORES * 5 + 8 + LED_STORES * 2
                         + PRE_RETIRES + RETIRES + CYCLE_GAP + 5 + 8 + RANDOM_OPS;
    localparam int LIMIT = OPS + 8 + 50;
    localparam logic [31:0] NOP     = 32'h0000_0013;
    localparam logic [31:0] BOOT_PC = 32'h4000_0000;

    logic                           clk;
    logic                           reset;
    logic [31:0]                    pc;
    logic [31:0]                    inst;
    logic [31:0]                    addr;
    logic [31:0]                    rs2_data;
    logic [31:0]                    wb_inst;
    logic [31:0]                    wb_data;
    logic                           retire;
    logic [mem_map_pkg::RAM_AW-1:0] fetch_addr;
    logic [31:0]                    load_data;
    logic                           load_valid;
    logic [31:0]                    fetch_inst;
    logic [31:0]                    led;
    logic                           br_inst;

    // Bit 32 marks a value that is captured rather than compared
    logic [32:0] exp_q[$];
    logic [32:0] exp_entry;
    logic [31:0] cap_q[$];
    logic [31:0] dmem_model [mem_map_pkg::RAM_WORDS];
    logic [31:0] imem_model [mem_map_pkg::RAM_WORDS];
    logic [31:0] led_model;
    int          errors;
    int          checks;
    int          cycle_count;

    tb_clock clock_i (
        .clk   (clk),
        .reset (reset)
    );

    mem_stage dut_i (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .inst       (inst),
        .addr       (addr),
        .rs2_data   (rs2_data),
        .wb_inst    (wb_inst),
        .wb_data    (wb_data),
        .retire     (retire),
        .fetch_addr (fetch_addr),
        .load_data  (load_data),
        .load_valid (load_valid),
        .fetch_inst (fetch_inst),
        .led        (led),
        .br_inst    (br_inst)
    );

    // RV32I load result from a memory word
    function automatic logic [31:0] expected_load(input logic [31:0] word,
                                                  input logic [2:0] f3,
                                                  input logic [1:0] off);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = word[16*off[1] +: 16];
        case (f3)
            riscv_pkg::FNC_LB:  return {{24{b[7]}}, b};
            riscv_pkg::FNC_LH:  return {{16{h[15]}}, h};
            riscv_pkg::FNC_LBU: return {24'd0, b};
            riscv_pkg::FNC_LHU: return {16'd0, h};
            default:            return word;
        endcase
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old_word,
                                                input logic [31:0] data,
                                                input logic [2:0] f3,
                                                input logic [1:0] off);
        logic [31:0] w;
        w = old_word;
        case (f3)
            riscv_pkg::FNC_SB: w[8*off +: 8] = data[7:0];
            riscv_pkg::FNC_SH: w[16*off[1] +: 16] = data[15:0];
            default:           w = data;
        endcase
        return w;
    endfunction

    function automatic logic [31:0] make_load(input logic [2:0] f3);
        return {12'h0, 5'd3, f3, 5'd7, riscv_pkg::OPC_LOAD_5, 2'b11};
    endfunction

    function automatic logic [31:0] make_store(input logic [2:0] f3, input logic [4:0] rs2);
        return {7'h0, rs2, 5'd3, f3, 5'd0, riscv_pkg::OPC_STORE_5, 2'b11};
    endfunction

    // Everything except stores and branches writes rd
    function automatic logic writes_rd(input logic [31:0] i);
        return (i[6:2] != riscv_pkg::OPC_STORE_5) && (i[6:2] != riscv_pkg::OPC_BRANCH_5);
    endfunction

    // Aligned offset for the access size in f3[1:0]
    function automatic logic [1:0] rand_offset(input logic [2:0] f3);
        logic [31:0] r;
        r = $urandom;
        case (f3[1:0])
            2'b00:   return r[1:0];
            2'b01:   return {r[0], 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [2:0] rand_store_f3();
        case ($urandom % 3)
            0:       return riscv_pkg::FNC_SB;
            1:       return riscv_pkg::FNC_SH;
            default: return riscv_pkg::FNC_SW;
        endcase
    endfunction

    function automatic logic [31:0] io_addr(input logic [3:0] offset, input logic [1:0] off);
        return {mem_map_pkg::ADDR_IO, 22'h0, offset, off};
    endfunction

    task automatic present(input logic [31:0] i_pc, input logic [31:0] i_inst,
                           input logic [31:0] i_addr, input logic [31:0] i_rs2,
                           input logic [31:0] i_wb_inst, input logic [31:0] i_wb_data,
                           input logic i_retire);
        @(posedge clk);
        pc       <= i_pc;
        inst     <= i_inst;
        addr     <= i_addr;
        rs2_data <= i_rs2;
        wb_inst  <= i_wb_inst;
        wb_data  <= i_wb_data;
        retire   <= i_retire;
    endtask

    task automatic idle(input logic i_retire);
        present(32'h0, NOP, 32'h0, 32'h0, NOP, 32'h0, i_retire);
    endtask

    // Routed by the I/O nibble, then the boot pc, then data memory
    task automatic store(input logic boot, input logic [2:0] f3,
                         input logic [31:0] a, input logic [31:0] data);
        present(boot ? BOOT_PC : 32'h0, make_store(f3, 5'd2), a, data, NOP, ~data, 1'b0);
        if (a[31:28] == mem_map_pkg::ADDR_IO) begin
            if (a[5:2] == mem_map_pkg::IO_LED) begin
                led_model = merge_store(led_model, data, f3, a[1:0]);
            end
        end else if (boot) begin
            imem_model[a[11:2]] = merge_store(imem_model[a[11:2]], data, f3, a[1:0]);
        end else begin
            dmem_model[a[11:2]] = merge_store(dmem_model[a[11:2]], data, f3, a[1:0]);
        end
    endtask

    task automatic forward_store(input int w, input logic [4:0] rs2, input logic [31:0] wb);
        logic [31:0] rs2_val;
        logic [31:0] wb_val;
        logic        fwd;
        rs2_val = $urandom;
        wb_val  = $urandom;
        fwd = writes_rd(wb) && (wb[11:7] != 5'd0) && (wb[11:7] == rs2);
        present(32'h0, make_store(riscv_pkg::FNC_SW, rs2), 32'(w * 4), rs2_val, wb, wb_val,
                1'b0);
        dmem_model[w] = fwd ? wb_val : rs2_val;
    endtask

    task automatic load(input int w, input logic [2:0] f3);
        logic [1:0] off;
        off = rand_offset(f3);
        present(32'h0, make_load(f3), 32'(w * 4) | 32'(off), $urandom, NOP, 32'h0, 1'b0);
        exp_q.push_back({1'b0, expected_load(dmem_model[w], f3, off)});
    endtask

    task automatic read_io(input logic [3:0] offset, input logic [31:0] value,
                           input logic capture);
        present(32'h0, make_load(riscv_pkg::FNC_LW), io_addr(offset, 2'b00), 32'h0, NOP,
                32'h0, 1'b0);
        exp_q.push_back({capture, value});
    endtask

    task automatic check_fetch(input int w);
        idle(1'b0);
        fetch_addr <= w[mem_map_pkg::RAM_AW-1:0];
        @(posedge clk);
        @(negedge clk);
        checks++;
        if (fetch_inst !== imem_model[w]) begin
            errors++;
            $display("FAIL at %0t: fetch_inst %h at word %0d, expected %h",
                     $time, fetch_inst, w, imem_model[w]);
        end
    endtask

    task automatic drain_loads();
        for (int i = 0; i < 4 && exp_q.size() != 0; i++) begin
            idle(1'b0);
        end
    endtask

    task automatic check_branch(input logic [31:0] i, input logic expected);
        present(32'h0, i, 32'h0, 32'h0, NOP, 32'h0, 1'b0);
        @(negedge clk);
        checks++;
        if (br_inst !== expected) begin
            errors++;
            $display("FAIL at %0t: br_inst %b for inst %h, expected %b",
                     $time, br_inst, i, expected);
        end
    endtask

    function automatic logic [31:0] random_non_branch();
        logic [31:0] r;
        logic [4:0]  opc;
        r = $urandom;
        case ($urandom % 6)
            0:       opc = riscv_pkg::OPC_ARI_RTYPE_5;
            1:       opc = riscv_pkg::OPC_ARI_ITYPE_5;
            2:       opc = riscv_pkg::OPC_LUI_5;
            3:       opc = riscv_pkg::OPC_AUIPC_5;
            4:       opc = riscv_pkg::OPC_JAL_5;
            default: opc = riscv_pkg::OPC_JALR_5;
        endcase
        return {r[31:7], opc, 2'b11};
    endfunction

    // Compare each returned load with the oldest expectation
    always @(negedge clk) begin
        if (load_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected load_valid at %0t with no load outstanding", $time);
            end else begin
                exp_entry = exp_q.pop_front();
                if (exp_entry[32]) begin
                    cap_q.push_back(load_data);
                end else begin
                    checks++;
                    if (load_data !== exp_entry[31:0]) begin
                        errors++;
                        $display("FAIL at %0t: load_data %h, expected %h",
                                 $time, load_data, exp_entry[31:0]);
                    end
                end
            end
        end
    end

    initial begin
        while (cycle_count < LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int          w;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [31:0] first_cycle;
        void'($urandom(91));
        errors      = 0;
        checks      = 0;
        cycle_count = 0;
        led_model   = '0;
        pc          = '0;
        inst        = NOP;
        addr        = '0;
        rs2_data    = '0;
        wb_inst     = NOP;
        wb_data     = '0;
        retire      = 1'b0;
        fetch_addr  = '0;
        wait (reset == 1'b0);

        // Data memory: fill, then random stores and all load formats
        for (w = 0; w < WIN; w++) begin
            store(1'b0, riscv_pkg::FNC_SW, 32'(w * 4), 32'h5a00_00a5 ^ (w * 32'h0101_0307));
        end
        for (int i = 0; i < ROUNDS; i++) begin
            w   = $urandom % WIN;
            f3  = rand_store_f3();
            off = rand_offset(f3);
            store(1'b0, f3, 32'(w * 4) | 32'(off), $urandom);
            load(w, riscv_pkg::FNC_LB);
            load(w, riscv_pkg::FNC_LH);
            load(w, riscv_pkg::FNC_LW);
            load(w, riscv_pkg::FNC_LBU);
            load(w, riscv_pkg::FNC_LHU);
        end
        drain_loads();

        // Boot-region stores go to instruction memory only
        for (w = 0; w < IMEM_STORES; w++) begin
            store(1'b1, riscv_pkg::FNC_SW, 32'(w * 4), $urandom);
            store(1'b1, riscv_pkg::FNC_SB, 32'(w * 4) | 32'(rand_offset(3'b000)), $urandom);
            check_fetch(w);
            load(w, riscv_pkg::FNC_LW);
        end
        drain_loads();

        // Forwarding from write-back
        forward_store(3, 5'd5, {12'h0, 5'd0, 3'b000, 5'd5, riscv_pkg::OPC_ARI_ITYPE_5, 2'b11});
        load(3, riscv_pkg::FNC_LW);
        forward_store(4, 5'd0, NOP);
        load(4, riscv_pkg::FNC_LW);
        forward_store(5, 5'd5, {7'h0, 5'd1, 5'd3, riscv_pkg::FNC_SW, 5'd5,
                                riscv_pkg::OPC_STORE_5, 2'b11});
        load(5, riscv_pkg::FNC_LW);
        forward_store(6, 5'd9, {12'h0, 5'd3, riscv_pkg::FNC_LW, 5'd9, riscv_pkg::OPC_LOAD_5,
                                2'b11});
        load(6, riscv_pkg::FNC_LW);

        // LED register
        for (int i = 0; i < LED_STORES; i++) begin
            f3 = rand_store_f3();
            store(1'b0, f3, io_addr(mem_map_pkg::IO_LED, rand_offset(f3)), $urandom);
            read_io(mem_map_pkg::IO_LED, led_model, 1'b0);
            @(negedge clk);
            checks++;
            if (led !== led_model) begin
                errors++;
                $display("FAIL at %0t: led %h, expected %h", $time, led, led_model);
            end
        end

        // Counters restart after clear, retired count nonzero before it
        repeat (PRE_RETIRES) idle(1'b1);
        store(1'b0, riscv_pkg::FNC_SW, io_addr(mem_map_pkg::IO_CLEAR, 2'b00), $urandom);
        read_io(mem_map_pkg::IO_CYCLE, 32'd0, 1'b0);
        read_io(mem_map_pkg::IO_INSTRET, 32'd0, 1'b0);
        repeat (RETIRES) idle(1'b1);
        read_io(mem_map_pkg::IO_INSTRET, RETIRES, 1'b0);
        read_io(mem_map_pkg::IO_CYCLE, 32'd0, 1'b1);
        repeat (CYCLE_GAP - 1) idle(1'b0);
        read_io(mem_map_pkg::IO_CYCLE, 32'd0, 1'b1);
        drain_loads();
        if (cap_q.size() != 2) begin
            errors++;
            $display("Cycle counter reads: got %0d results instead of 2", cap_q.size());
        end else begin
            first_cycle = cap_q[0];
            checks++;
            if (cap_q[1] - first_cycle != CYCLE_GAP) begin
                errors++;
                $display("FAIL at %0t: cycle counter moved %0d over %0d cycles",
                         $time, cap_q[1] - first_cycle, CYCLE_GAP);
            end
        end

        // Branch decode
        for (int i = 0; i < 8; i++) begin
            f3 = 3'(i);
            check_branch({7'h0, 5'd1, 5'd2, f3, 5'd0, riscv_pkg::OPC_BRANCH_5, 2'b11},
                         (f3 != 3'b010) && (f3 != 3'b011));
        end
        for (int i = 0; i < RANDOM_OPS; i++) begin
            check_branch(random_non_branch(), 1'b0);
        end

        drain_loads();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected loads never arrived", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic reset
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verilog/byte_ram.sv
`timescale 1ns/1ps

module byte_ram (
    input  logic                           clk,
    input  logic                           reset,
    mem_port_if.target                     port,
    input  logic [mem_map_pkg::RAM_AW-1:0] fetch_addr,
    output logic [31:0]                    fetch_data
);

    logic [31:0] mem [0:mem_map_pkg::RAM_WORDS-1];

    // Byte-masked write
    always_ff @(posedge clk) begin
        if (port.en && port.we) begin
            for (int i = 0; i < 4; i++) begin
                if (port.wmask[i]) begin
                    mem[port.addr][8*i +: 8] <= port.wdata[8*i +: 8];
                end
            end
        end
    end

    // Both reads return the old word on a same-cycle write
    always_ff @(posedge clk) begin
        if (reset) begin
            port.rdata <= '0;
            fetch_data <= '0;
        end else begin
            if (port.en) begin
                port.rdata <= mem[port.addr];
            end
            fetch_data <= mem[fetch_addr];
        end
    end

endmodule

//--- verilog/io_regs.sv
`timescale 1ns/1ps

module io_regs (
    input  logic        clk,
    input  logic        reset,
    input  logic        retire,
    mem_port_if.target  port,
    output logic [31:0] led
);

    logic [31:0] cycle_cnt;
    logic [31:0] instret_cnt;
    logic [3:0]  offset;
    logic        wr;

    assign offset = port.addr[3:0];
    assign wr     = port.en && port.we;

    always_ff @(posedge clk) begin
        if (reset) begin
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else if (wr && offset == mem_map_pkg::IO_CLEAR) begin
            cycle_cnt   <= '0;
            instret_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 32'd1;
            if (retire) begin
                instret_cnt <= instret_cnt + 32'd1;
            end
        end
    end

    // LED register, byte lanes under wmask
    always_ff @(posedge clk) begin
        if (reset) begin
            led <= '0;
        end else if (wr && offset == mem_map_pkg::IO_LED) begin
            for (int i = 0; i < 4; i++) begin
                if (port.wmask[i]) begin
                    led[8*i +: 8] <= port.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            port.rdata <= '0;
        end else if (port.en) begin
            case (offset)
                mem_map_pkg::IO_LED:     port.rdata <= led;
                mem_map_pkg::IO_CYCLE:   port.rdata <= cycle_cnt;
                mem_map_pkg::IO_INSTRET: port.rdata <= instret_cnt;
                default:                 port.rdata <= '0;
            endcase
        end
    end

endmodule

//--- verilog/load_unit.sv
`timescale 1ns/1ps

module load_unit (
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] inst,
    input  logic [31:0] addr,
    input  logic        load_en,
    input  logic [31:0] dmem_rdata,
    input  logic [31:0] io_rdata,
    output logic [31:0] load_data,
    output logic        load_valid
);

    logic [2:0]             funct3_q;
    logic [1:0]             offset_q;
    logic                   io_sel_q;
    mem_map_pkg::mem_word_u word;
    logic [7:0]             sel_byte;
    logic [15:0]            sel_half;

    always_ff @(posedge clk) begin
        if (reset) begin
            load_valid <= 1'b0;
        end else begin
            load_valid <= load_en;
        end
    end

    // Format of the load in flight
    always_ff @(posedge clk) begin
        funct3_q <= inst[riscv_pkg::FUNCT3_MSB:riscv_pkg::FUNCT3_LSB];
        offset_q <= addr[1:0];
        io_sel_q <= (addr[31:28] == mem_map_pkg::ADDR_IO);
    end

    assign word     = io_sel_q ? io_rdata : dmem_rdata;
    assign sel_byte = word.bytes[offset_q];
    assign sel_half = word.halves[offset_q[1]];

    always_comb begin
        case (funct3_q)
            riscv_pkg::FNC_LB:  load_data = {{24{sel_byte[7]}}, sel_byte};
            riscv_pkg::FNC_LH:  load_data = {{16{sel_half[15]}}, sel_half};
            riscv_pkg::FNC_LBU: load_data = {24'd0, sel_byte};
            riscv_pkg::FNC_LHU: load_data = {16'd0, sel_half};
            // LW and anything else passes the word through
            default:            load_data = word;
        endcase
    end

endmodule

//--- verilog/mem_control.sv
`timescale 1ns/1ps

module mem_control (
    input  logic [31:0]        pc,
    input  logic [31:0]        addr,
    input  logic [31:0]        inst,
    input  logic [31:0]        wb_inst,
    output logic               din_sel,
    output logic               br_inst,
    output mem_map_pkg::size_e size,
    output logic               imem_en,
    output logic               dmem_en,
    output logic               io_en,
    output logic               load_en
);

    logic [4:0] opcode5;
    logic [2:0] funct3;
    logic [4:0] rs2;
    logic [4:0] wb_opcode5;
    logic [4:0] wb_rd;
    logic       wb_writes;
    logic       is_io;
    logic       store_en;

    assign opcode5    = inst[riscv_pkg::OPC5_MSB:riscv_pkg::OPC5_LSB];
    assign funct3     = inst[riscv_pkg::FUNCT3_MSB:riscv_pkg::FUNCT3_LSB];
    assign rs2        = inst[riscv_pkg::RS2_MSB:riscv_pkg::RS2_LSB];
    assign wb_opcode5 = wb_inst[riscv_pkg::OPC5_MSB:riscv_pkg::OPC5_LSB];
    assign wb_rd      = wb_inst[riscv_pkg::RD_MSB:riscv_pkg::RD_LSB];

    assign is_io = (addr[31:28] == mem_map_pkg::ADDR_IO);

    always_comb begin
        size    = mem_map_pkg::SIZE_NONE;
        br_inst = 1'b0;
        load_en = 1'b0;
        case (opcode5)
            riscv_pkg::OPC_LOAD_5: begin
                case (funct3)
                    riscv_pkg::FNC_LB, riscv_pkg::FNC_LH, riscv_pkg::FNC_LW,
                    riscv_pkg::FNC_LBU, riscv_pkg::FNC_LHU: load_en = 1'b1;
                    default: ;
                endcase
            end
            riscv_pkg::OPC_STORE_5: begin
                case (funct3)
                    riscv_pkg::FNC_SB: size = mem_map_pkg::SIZE_BYTE;
                    riscv_pkg::FNC_SH: size = mem_map_pkg::SIZE_HALF;
                    riscv_pkg::FNC_SW: size = mem_map_pkg::SIZE_WORD;
                    default: ;
                endcase
            end
            riscv_pkg::OPC_BRANCH_5: begin
                case (funct3)
                    riscv_pkg::FNC_BEQ, riscv_pkg::FNC_BNE, riscv_pkg::FNC_BLT,
                    riscv_pkg::FNC_BGE, riscv_pkg::FNC_BLTU, riscv_pkg::FNC_BGEU: br_inst = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign store_en = (size != mem_map_pkg::SIZE_NONE);

    // Store routing: I/O region first, then boot region by pc
    assign io_en   = (store_en || load_en) && is_io;
    assign imem_en = store_en && !is_io && pc[30];
    assign dmem_en = !is_io && ((store_en && !pc[30]) || load_en);

    // Opcodes that write rd
    always_comb begin
        case (wb_opcode5)
            riscv_pkg::OPC_LOAD_5, riscv_pkg::OPC_ARI_RTYPE_5, riscv_pkg::OPC_ARI_ITYPE_5,
            riscv_pkg::OPC_JAL_5, riscv_pkg::OPC_JALR_5, riscv_pkg::OPC_LUI_5,
            riscv_pkg::OPC_AUIPC_5: wb_writes = 1'b1;
            default: wb_writes = 1'b0;
        endcase
    end

    assign din_sel = (opcode5 == riscv_pkg::OPC_STORE_5) && wb_writes
                     && (wb_rd != 5'd0) && (wb_rd == rs2);

    // Loads aligned to their size
    always_comb begin
        assert final (!load_en || funct3[1:0] == 2'b00
                      || (funct3[1:0] == 2'b01 && !addr[0])
                      || (funct3[1:0] == 2'b10 && addr[1:0] == 2'b00))
            else $error("misaligned load from 0x%08h", addr);
    end

endmodule

//--- verilog/mem_map_pkg.sv
package mem_map_pkg;

    // Top nibble of the I/O region
    localparam logic [3:0] ADDR_IO = 4'h8;

    // I/O word offsets, addr[5:2]
    localparam logic [3:0] IO_LED     = 4'h0;
    localparam logic [3:0] IO_CYCLE   = 4'h1;
    localparam logic [3:0] IO_INSTRET = 4'h2;
    localparam logic [3:0] IO_CLEAR   = 4'h3;

    // Depth of each RAM in words
    localparam int RAM_WORDS = 1024;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2,
        SIZE_NONE = 2'd3
    } size_e;

    // One memory word as byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
    } mem_word_u;

endpackage

//--- verilog/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;

    logic                           en;
    logic                           we;
    logic [mem_map_pkg::RAM_AW-1:0] addr;
    logic [3:0]                     wmask;
    logic [31:0]                    wdata;
    // Valid the cycle after en
    logic [31:0]                    rdata;

    modport host (
        output en, we, addr, wmask, wdata,
        input  rdata
    );

    modport target (
        input  en, we, addr, wmask, wdata,
        output rdata
    );

endinterface

//--- verilog/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [31:0]                    pc,
    input  logic [31:0]                    inst,
    input  logic [31:0]                    addr,
    input  logic [31:0]                    rs2_data,
    input  logic [31:0]                    wb_inst,
    input  logic [31:0]                    wb_data,
    input  logic                           retire,
    input  logic [mem_map_pkg::RAM_AW-1:0] fetch_addr,
    output logic [31:0]                    load_data,
    output logic                           load_valid,
    output logic [31:0]                    fetch_inst,
    output logic [31:0]                    led,
    output logic                           br_inst
);

    logic               din_sel;
    mem_map_pkg::size_e size;
    logic               imem_en;
    logic               dmem_en;
    logic               io_en;
    logic               load_en;

    mem_port_if imem_port ();
    mem_port_if dmem_port ();
    mem_port_if io_port ();

    mem_control ctrl_i (
        .pc      (pc),
        .addr    (addr),
        .inst    (inst),
        .wb_inst (wb_inst),
        .din_sel (din_sel),
        .br_inst (br_inst),
        .size    (size),
        .imem_en (imem_en),
        .dmem_en (dmem_en),
        .io_en   (io_en),
        .load_en (load_en)
    );

    store_unit store_i (
        .addr     (addr),
        .rs2_data (rs2_data),
        .wb_data  (wb_data),
        .din_sel  (din_sel),
        .imem_en  (imem_en),
        .dmem_en  (dmem_en),
        .io_en    (io_en),
        .load_en  (load_en),
        .size     (size),
        .imem     (imem_port.host),
        .dmem     (dmem_port.host),
        .io       (io_port.host)
    );

    byte_ram imem_i (
        .clk        (clk),
        .reset      (reset),
        .port       (imem_port.target),
        .fetch_addr (fetch_addr),
        .fetch_data (fetch_inst)
    );

    // No fetch path into data memory
    byte_ram dmem_i (
        .clk        (clk),
        .reset      (reset),
        .port       (dmem_port.target),
        .fetch_addr ('0),
        .fetch_data ()
    );

    io_regs io_i (
        .clk    (clk),
        .reset  (reset),
        .retire (retire),
        .port   (io_port.target),
        .led    (led)
    );

    load_unit load_i (
        .clk        (clk),
        .reset      (reset),
        .inst       (inst),
        .addr       (addr),
        .load_en    (load_en),
        .dmem_rdata (dmem_port.rdata),
        .io_rdata   (io_port.rdata),
        .load_data  (load_data),
        .load_valid (load_valid)
    );

endmodule

//--- verilog/riscv_pkg.sv
package riscv_pkg;

    // Major opcodes, inst[6:2]
    localparam logic [4:0] OPC_LOAD_5      = 5'b00000;
    localparam logic [4:0] OPC_STORE_5     = 5'b01000;
    localparam logic [4:0] OPC_BRANCH_5    = 5'b11000;
    localparam logic [4:0] OPC_ARI_RTYPE_5 = 5'b01100;
    localparam logic [4:0] OPC_ARI_ITYPE_5 = 5'b00100;
    localparam logic [4:0] OPC_JAL_5       = 5'b11011;
    localparam logic [4:0] OPC_JALR_5      = 5'b11001;
    localparam logic [4:0] OPC_LUI_5       = 5'b01101;
    localparam logic [4:0] OPC_AUIPC_5     = 5'b00101;

    // Load funct3
    localparam logic [2:0] FNC_LB  = 3'b000;
    localparam logic [2:0] FNC_LH  = 3'b001;
    localparam logic [2:0] FNC_LW  = 3'b010;
    localparam logic [2:0] FNC_LBU = 3'b100;
    localparam logic [2:0] FNC_LHU = 3'b101;

    // Store funct3
    localparam logic [2:0] FNC_SB = 3'b000;
    localparam logic [2:0] FNC_SH = 3'b001;
    localparam logic [2:0] FNC_SW = 3'b010;

    // Branch funct3
    localparam logic [2:0] FNC_BEQ  = 3'b000;
    localparam logic [2:0] FNC_BNE  = 3'b001;
    localparam logic [2:0] FNC_BLT  = 3'b100;
    localparam logic [2:0] FNC_BGE  = 3'b101;
    localparam logic [2:0] FNC_BLTU = 3'b110;
    localparam logic [2:0] FNC_BGEU = 3'b111;

    // Instruction field positions
    localparam int OPC5_LSB   = 2;
    localparam int OPC5_MSB   = 6;
    localparam int RD_LSB     = 7;
    localparam int RD_MSB     = 11;
    localparam int FUNCT3_LSB = 12;
    localparam int FUNCT3_MSB = 14;
    localparam int RS2_LSB    = 20;
    localparam int RS2_MSB    = 24;

endpackage

//--- verilog/store_unit.sv
`timescale 1ns/1ps

module store_unit (
    input  logic [31:0]        addr,
    input  logic [31:0]        rs2_data,
    input  logic [31:0]        wb_data,
    input  logic               din_sel,
    input  logic               imem_en,
    input  logic               dmem_en,
    input  logic               io_en,
    input  logic               load_en,
    input  mem_map_pkg::size_e size,
    mem_port_if.host           imem,
    mem_port_if.host           dmem,
    mem_port_if.host           io
);

    logic [31:0]                    store_data;
    logic [31:0]                    wdata;
    logic [3:0]                     wmask;
    logic [1:0]                     offset;
    logic [mem_map_pkg::RAM_AW-1:0] word_addr;
    logic                           aligned;

    assign offset     = addr[1:0];
    assign word_addr  = addr[mem_map_pkg::RAM_AW+1:2];
    // Forwarded write-back value wins
    assign store_data = din_sel ? wb_data : rs2_data;

    always_comb begin
        case (size)
            mem_map_pkg::SIZE_BYTE: begin
                wdata = {4{store_data[7:0]}};
                wmask = 4'b0001 << offset;
            end
            mem_map_pkg::SIZE_HALF: begin
                wdata = {2{store_data[15:0]}};
                wmask = offset[1] ? 4'b1100 : 4'b0011;
            end
            mem_map_pkg::SIZE_WORD: begin
                wdata = store_data;
                wmask = 4'b1111;
            end
            default: begin
                wdata = store_data;
                wmask = 4'b0000;
            end
        endcase
    end

    assign imem.en    = imem_en;
    assign imem.we    = imem_en && !load_en;
    assign imem.addr  = word_addr;
    assign imem.wmask = wmask;
    assign imem.wdata = wdata;

    assign dmem.en    = dmem_en;
    assign dmem.we    = dmem_en && !load_en;
    assign dmem.addr  = word_addr;
    assign dmem.wmask = wmask;
    assign dmem.wdata = wdata;

    assign io.en    = io_en;
    assign io.we    = io_en && !load_en;
    assign io.addr  = word_addr;
    assign io.wmask = wmask;
    assign io.wdata = wdata;

    assign aligned = (size == mem_map_pkg::SIZE_BYTE)
                     || (size == mem_map_pkg::SIZE_HALF && !offset[0])
                     || (size == mem_map_pkg::SIZE_WORD && offset == 2'b00);

    always_comb begin
        assert final (load_en || !(imem_en || dmem_en || io_en) || aligned)
            else $error("misaligned store to 0x%08h", addr);
    end

endmodule

//--- vlog.f
verilog/riscv_pkg.sv
verilog/mem_map_pkg.sv
verilog/mem_port_if.sv
verilog/mem_control.sv
verilog/store_unit.sv
verilog/byte_ram.sv
verilog/io_regs.sv
verilog/load_unit.sv
verilog/mem_stage.sv
tests/tb_clock.sv
tests/mem_stage_tb.sv
